/* design/pic_prio_pkg.sv */
////////////////////////////////////////
// PIC priority definitions
// Source count, id and priority widths
// and the strongest priority level
////////////////////////////////////////

`default_nettype none

package pic_prio_pkg;

   // Gateway slots, slot 0 reserved
   localparam int NUM_SRC   = 16;

   localparam int ID_BITS   = 4;
   localparam int PRIO_BITS = 4;

   typedef logic [ID_BITS-1:0]   id_t;
   typedef logic [PRIO_BITS-1:0] prio_t;

   // Strongest level in normal order
   localparam prio_t PRIO_MAX = prio_t'(15);

endpackage

`default_nettype wire

/* design/pic_map_pkg.sv */
////////////////////////////////////////
// PIC address map
// Register regions, gateway config bit
// positions and the address decode view
////////////////////////////////////////

`default_nettype none

package pic_map_pkg;

   localparam logic [31:0] PIC_BASE   = 32'hF00C_0000;

   localparam logic [31:0] PRIO_OFS   = 32'h0000_0000;
   localparam logic [31:0] PEND_OFS   = 32'h0000_1000;
   localparam logic [31:0] ENABLE_OFS = 32'h0000_2000;
   localparam logic [31:0] CONFIG_OFS = 32'h0000_3000;   // Single word
   localparam logic [31:0] GWCFG_OFS  = 32'h0000_4000;
   localparam logic [31:0] GWCLR_OFS  = 32'h0000_5000;

   // Gateway config word
   localparam int GWCFG_POL_BIT  = 0;
   localparam int GWCFG_TYPE_BIT = 1;   // 1 selects edge

   typedef logic [31-pic_prio_pkg::ID_BITS-2:0] region_t;

   typedef struct packed {
      region_t                          region;     // Matched against region bases
      logic [pic_prio_pkg::ID_BITS-1:0] idx;        // Source index
      logic [1:0]                       byte_ofs;
   } pic_addr_fields_t;

   typedef union packed {
      logic [31:0]      word;   // Exact match view
      pic_addr_fields_t f;
   } pic_addr_u;

endpackage

`default_nettype wire

/* design/pic_cfg_if.sv */
////////////////////////////////////////
// PIC per-source configuration
// Carries enable, priority and gateway
// settings out of the register file
////////////////////////////////////////

`default_nettype none

interface pic_cfg_if;

   logic [pic_prio_pkg::NUM_SRC-1:0]                       enable;
   pic_prio_pkg::prio_t [pic_prio_pkg::NUM_SRC-1:0]        prio;
   logic [pic_prio_pkg::NUM_SRC-1:0]                       gw_pol;
   logic [pic_prio_pkg::NUM_SRC-1:0]                       gw_edge;
   logic [pic_prio_pkg::NUM_SRC-1:0]                       gw_clr;   // One-cycle pulses

   modport regs (
      output enable, prio, gw_pol, gw_edge, gw_clr
   );

   modport gw (
      input gw_pol, gw_edge, gw_clr
   );

   modport arb (
      input enable, prio
   );

endinterface

`default_nettype wire

/* design/pic_regs.sv */
////////////////////////////////////////
// PIC register file
// Flops the access port, decodes the
// address and holds priority, enable,
// gateway config and order registers
////////////////////////////////////////

`default_nettype none

module pic_regs (
   input  logic                             clk,
   input  logic                             arst_n,
   input  logic                             rden,
   input  logic [31:0]                      rdaddr,
   input  logic                             wren,
   input  logic [31:0]                      wraddr,
   input  logic [31:0]                      wr_data,
   output logic [31:0]                      rd_data,
   input  logic [pic_prio_pkg::NUM_SRC-1:0] gw_pend,
   output logic                             priord,
   pic_cfg_if.regs                          cfg
);

   logic                   rden_q;
   logic                   wren_q;
   pic_map_pkg::pic_addr_u raddr_q;
   pic_map_pkg::pic_addr_u waddr_q;
   logic [31:0]            wr_data_q;

   pic_prio_pkg::prio_t [pic_prio_pkg::NUM_SRC-1:0] prio_q;
   logic [pic_prio_pkg::NUM_SRC-1:0] enable_q;
   logic [pic_prio_pkg::NUM_SRC-1:0] gw_pol_q;
   logic [pic_prio_pkg::NUM_SRC-1:0] gw_edge_q;
   logic [pic_prio_pkg::NUM_SRC-1:0] clr_pulse;
   logic                             priord_q;

   logic wr_slot;
   logic wr_prio;
   logic wr_enable;
   logic wr_gwcfg;
   logic wr_gwclr;
   logic wr_config;

   // Region field of an absolute register address
   function automatic pic_map_pkg::region_t region_of(input logic [31:0] ofs);
      pic_map_pkg::pic_addr_u a;
      a.word = pic_map_pkg::PIC_BASE + ofs;
      return a.f.region;
   endfunction

   ////////////////////////////////////////
   // Access port flops

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rden_q <= 1'b0;
         wren_q <= 1'b0;
      end else begin
         rden_q <= rden;
         wren_q <= wren;
      end
   end

   always_ff @(posedge clk) begin
      raddr_q   <= rdaddr;
      waddr_q   <= wraddr;
      wr_data_q <= wr_data;
   end

   ////////////////////////////////////////
   // Write decode

   assign wr_slot   = (waddr_q.f.idx != '0);   // Slot 0 stays zero
   assign wr_prio   = wren_q && wr_slot && (waddr_q.f.region == region_of(pic_map_pkg::PRIO_OFS));
   assign wr_enable = wren_q && wr_slot && (waddr_q.f.region == region_of(pic_map_pkg::ENABLE_OFS));
   assign wr_gwcfg  = wren_q && wr_slot && (waddr_q.f.region == region_of(pic_map_pkg::GWCFG_OFS));
   assign wr_gwclr  = wren_q && wr_slot && (waddr_q.f.region == region_of(pic_map_pkg::GWCLR_OFS));
   assign wr_config = wren_q && (waddr_q.word == pic_map_pkg::PIC_BASE + pic_map_pkg::CONFIG_OFS);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         prio_q    <= '0;
         enable_q  <= '0;
         gw_pol_q  <= '0;
         gw_edge_q <= '0;
         priord_q  <= 1'b0;
      end else begin
         if (wr_prio) prio_q[waddr_q.f.idx] <= wr_data_q[pic_prio_pkg::PRIO_BITS-1:0];
         if (wr_enable) enable_q[waddr_q.f.idx] <= wr_data_q[0];
         if (wr_gwcfg) begin
            gw_pol_q[waddr_q.f.idx]  <= wr_data_q[pic_map_pkg::GWCFG_POL_BIT];
            gw_edge_q[waddr_q.f.idx] <= wr_data_q[pic_map_pkg::GWCFG_TYPE_BIT];
         end
         if (wr_config) priord_q <= wr_data_q[0];
      end
   end

   always_comb begin
      clr_pulse = '0;
      if (wr_gwclr) clr_pulse[waddr_q.f.idx] = 1'b1;   // Lasts the one write cycle
   end

   assign cfg.enable  = enable_q;
   assign cfg.prio    = prio_q;
   assign cfg.gw_pol  = gw_pol_q;
   assign cfg.gw_edge = gw_edge_q;
   assign cfg.gw_clr  = clr_pulse;
   assign priord      = priord_q;

   ////////////////////////////////////////
   // Read data mux

   always_comb begin
      rd_data = '0;
      if (rden_q) begin
         if (raddr_q.word == pic_map_pkg::PIC_BASE + pic_map_pkg::CONFIG_OFS) begin
            rd_data[0] = priord_q;
         end else if (raddr_q.f.region == region_of(pic_map_pkg::PEND_OFS)) begin
            if (raddr_q.f.idx == '0) rd_data[pic_prio_pkg::NUM_SRC-1:0] = gw_pend;
         end else if (raddr_q.f.region == region_of(pic_map_pkg::PRIO_OFS)) begin
            rd_data[pic_prio_pkg::PRIO_BITS-1:0] = prio_q[raddr_q.f.idx];
         end else if (raddr_q.f.region == region_of(pic_map_pkg::ENABLE_OFS)) begin
            rd_data[0] = enable_q[raddr_q.f.idx];
         end else if (raddr_q.f.region == region_of(pic_map_pkg::GWCFG_OFS)) begin
            rd_data[pic_map_pkg::GWCFG_POL_BIT]  = gw_pol_q[raddr_q.f.idx];
            rd_data[pic_map_pkg::GWCFG_TYPE_BIT] = gw_edge_q[raddr_q.f.idx];
         end
      end
   end

endmodule

`default_nettype wire

/* design/pic_gateway_bank.sv */
////////////////////////////////////////
// PIC gateway bank
// Two-flop synchronizers, polarity and
// level or edge gateways per source
////////////////////////////////////////

`default_nettype none

module pic_gateway_bank (
   input  logic                             clk,
   input  logic                             arst_n,
   input  logic [pic_prio_pkg::NUM_SRC-1:0] extintsrc_req,
   pic_cfg_if.gw                            cfg,
   output logic [pic_prio_pkg::NUM_SRC-1:0] gw_pend
);

   logic [pic_prio_pkg::NUM_SRC-1:0] sync1_q;
   logic [pic_prio_pkg::NUM_SRC-1:0] sync2_q;
   logic [pic_prio_pkg::NUM_SRC-1:0] req;
   logic [pic_prio_pkg::NUM_SRC-1:0] edge_q;
   logic [pic_prio_pkg::NUM_SRC-1:0] pend_all;

   ////////////////////////////////////////
   // Synchronizers

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sync1_q <= '0;
         sync2_q <= '0;
      end else begin
         sync1_q <= extintsrc_req;
         sync2_q <= sync1_q;
      end
   end

   assign req = sync2_q ^ cfg.gw_pol;   // Active-high request

   ////////////////////////////////////////
   // Edge latches

   // Held until software clears it, dropped in level mode
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         edge_q <= '0;
      end else begin
         edge_q <= cfg.gw_edge & (req | (edge_q & ~cfg.gw_clr));
      end
   end

   assign pend_all = req | (cfg.gw_edge & edge_q);

   assign gw_pend = {pend_all[pic_prio_pkg::NUM_SRC-1:1], 1'b0};   // Id 0 never requests

endmodule

`default_nettype wire

/* design/pic_arbiter.sv */
////////////////////////////////////////
// PIC arbiter
// Masks and orders priorities, then a
// compare tree selects the winner
////////////////////////////////////////

`default_nettype none

module pic_arbiter (
   pic_cfg_if.arb                           cfg,
   input  logic [pic_prio_pkg::NUM_SRC-1:0] gw_pend,
   input  logic                             priord,
   output pic_prio_pkg::id_t                win_id,
   output pic_prio_pkg::prio_t              win_prio_eff
);

   // Tree nodes, root at 0, children of n at 2n+1 and 2n+2
   pic_prio_pkg::id_t   node_id   [2*pic_prio_pkg::NUM_SRC-1];
   pic_prio_pkg::prio_t node_prio [2*pic_prio_pkg::NUM_SRC-1];

   ////////////////////////////////////////
   // Leaves

   for (genvar i = 0; i < pic_prio_pkg::NUM_SRC; i++) begin : g_leaf
      pic_prio_pkg::prio_t prio_ord;

      assign prio_ord = priord ? ~cfg.prio[i] : cfg.prio[i];   // Larger always wins

      assign node_id[pic_prio_pkg::NUM_SRC-1+i]   = pic_prio_pkg::id_t'(i);
      assign node_prio[pic_prio_pkg::NUM_SRC-1+i] = (gw_pend[i] && cfg.enable[i]) ? prio_ord : '0;
   end

   ////////////////////////////////////////
   // Compare and select

   for (genvar l = 0; l < $clog2(pic_prio_pkg::NUM_SRC); l++) begin : g_level
      for (genvar n = (1 << l) - 1; n < (2 << l) - 1; n++) begin : g_node
         logic right_wins;

         // Left child holds the lower ids and keeps a tie
         assign right_wins   = node_prio[2*n+2] > node_prio[2*n+1];
         assign node_id[n]   = right_wins ? node_id[2*n+2] : node_id[2*n+1];
         assign node_prio[n] = right_wins ? node_prio[2*n+2] : node_prio[2*n+1];
      end
   end

   assign win_id       = node_id[0];
   assign win_prio_eff = node_prio[0];   // Id 0, priority 0 when idle

endmodule

`default_nettype wire

/* design/pic_notify.sv */
////////////////////////////////////////
// PIC notification
// Threshold compare and the claim id,
// priority level and wake-up flops
////////////////////////////////////////

`default_nettype none

module pic_notify (
   input  logic                clk,
   input  logic                arst_n,
   input  pic_prio_pkg::id_t   win_id,
   input  pic_prio_pkg::prio_t win_prio_eff,
   input  logic                priord,
   input  pic_prio_pkg::prio_t meipt,
   input  pic_prio_pkg::prio_t meicurpl,
   output logic                mexintpend,
   output logic                mhwakeup,
   output pic_prio_pkg::id_t   claimid,
   output pic_prio_pkg::prio_t pl
);

   pic_prio_pkg::prio_t meipt_eff;
   pic_prio_pkg::prio_t curpl_eff;
   pic_prio_pkg::prio_t pl_sw;
   logic                pend_d;
   logic                wake_d;

   // Thresholds in effective order
   assign meipt_eff = priord ? ~meipt : meipt;
   assign curpl_eff = priord ? ~meicurpl : meicurpl;

   assign pend_d = (win_prio_eff > meipt_eff) && (win_prio_eff > curpl_eff);
   assign wake_d = (win_prio_eff == pic_prio_pkg::PRIO_MAX);
   assign pl_sw  = priord ? ~win_prio_eff : win_prio_eff;   // Back to software order

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mexintpend <= 1'b0;
         mhwakeup   <= 1'b0;
         claimid    <= '0;
         pl         <= '0;
      end else begin
         mexintpend <= pend_d;
         mhwakeup   <= wake_d;
         claimid    <= win_id;
         pl         <= pl_sw;
      end
   end

endmodule

`default_nettype wire

/* design/pic_ctrl.sv */
////////////////////////////////////////
// Programmable interrupt controller
// Gateways, register file, arbiter and
// notification for 15 sources
////////////////////////////////////////

`default_nettype none

module pic_ctrl (
   input  logic                             clk,
   input  logic                             arst_n,
   input  logic [pic_prio_pkg::NUM_SRC-1:0] extintsrc_req,   // Bit 0 ignored
   input  logic                             rden,
   input  logic [31:0]                      rdaddr,
   input  logic                             wren,
   input  logic [31:0]                      wraddr,
   input  logic [31:0]                      wr_data,
   output logic [31:0]                      rd_data,
   input  pic_prio_pkg::prio_t              meipt,
   input  pic_prio_pkg::prio_t              meicurpl,
   output logic                             mexintpend,
   output logic                             mhwakeup,
   output pic_prio_pkg::id_t                claimid,
   output pic_prio_pkg::prio_t              pl
);

   logic [pic_prio_pkg::NUM_SRC-1:0] gw_pend;
   logic                             priord;   // Reversed priority order
   pic_prio_pkg::id_t                win_id;
   pic_prio_pkg::prio_t              win_prio_eff;

   pic_cfg_if i_cfg ();

   pic_regs i_regs (
      .clk     (clk),
      .arst_n  (arst_n),
      .rden    (rden),
      .rdaddr  (rdaddr),
      .wren    (wren),
      .wraddr  (wraddr),
      .wr_data (wr_data),
      .rd_data (rd_data),
      .gw_pend (gw_pend),
      .priord  (priord),
      .cfg     (i_cfg.regs)
   );

   pic_gateway_bank i_gw (
      .clk           (clk),
      .arst_n        (arst_n),
      .extintsrc_req (extintsrc_req),
      .cfg           (i_cfg.gw),
      .gw_pend       (gw_pend)
   );

   pic_arbiter i_arb (
      .cfg          (i_cfg.arb),
      .gw_pend      (gw_pend),
      .priord       (priord),
      .win_id       (win_id),
      .win_prio_eff (win_prio_eff)
   );

   pic_notify i_notify (
      .clk          (clk),
      .arst_n       (arst_n),
      .win_id       (win_id),
      .win_prio_eff (win_prio_eff),
      .priord       (priord),
      .meipt        (meipt),
      .meicurpl     (meicurpl),
      .mexintpend   (mexintpend),
      .mhwakeup     (mhwakeup),
      .claimid      (claimid),
      .pl           (pl)
   );

endmodule

`default_nettype wire

/* test/pic_ctrl_props.sv */
////////////////////////////////////////
// PIC controller properties
// Reset values, threshold rule and the
// wake-up level on the top-level outputs
////////////////////////////////////////

`default_nettype none

module pic_ctrl_props (
   input logic                clk,
   input logic                arst_n,
   input logic                priord,
   input pic_prio_pkg::prio_t meipt,
   input pic_prio_pkg::prio_t meicurpl,
   input logic                mexintpend,
   input logic                mhwakeup,
   input pic_prio_pkg::id_t   claimid,
   input pic_prio_pkg::prio_t pl,
   input logic [31:0]         rd_data
);

   int fail_cnt = 0;

   // Strictly stronger in the given order
   function automatic logic beats(input pic_prio_pkg::prio_t a, input pic_prio_pkg::prio_t b,
                                  input logic rev);
      return rev ? (a < b) : (a > b);
   endfunction

   a_reset_zero : assert property (@(posedge clk)
      !arst_n |-> (!mexintpend && !mhwakeup && claimid == '0 && pl == '0 && rd_data == '0))
   else begin
      fail_cnt++;
      $error("Outputs not zero during reset");
   end

   // Outputs are flopped one cycle after the inputs they were compared with
   a_pend_thresh : assert property (@(posedge clk) disable iff (!arst_n)
      mexintpend |-> (beats(pl, $past(meipt), $past(priord))
                      && beats(pl, $past(meicurpl), $past(priord))))
   else begin
      fail_cnt++;
      $error("mexintpend set while pl does not pass both thresholds");
   end

   a_wake_level : assert property (@(posedge clk) disable iff (!arst_n)
      mhwakeup == (pl == ($past(priord) ? 4'h0 : 4'hF)))
   else begin
      fail_cnt++;
      $error("mhwakeup does not match the strongest level");
   end

endmodule

bind pic_ctrl pic_ctrl_props i_props (
   .clk        (clk),
   .arst_n     (arst_n),
   .priord     (priord),
   .meipt      (meipt),
   .meicurpl   (meicurpl),
   .mexintpend (mexintpend),
   .mhwakeup   (mhwakeup),
   .claimid    (claimid),
   .pl         (pl),
   .rd_data    (rd_data)
);

`default_nettype wire

/* test/pic_ctrl_tb.sv */
////////////////////////////////////////
// PIC controller testbench
// Register access, level and edge
// sources, random arbitration and the
// reversed priority order
////////////////////////////////////////

`default_nettype none

module pic_ctrl_tb;

   localparam int MAX_CYCLES = 4000;   // About twice the test length

   logic                clk;
   logic                arst_n;
   logic [15:0]         extintsrc_req;
   logic                rden;
   logic [31:0]         rdaddr;
   logic                wren;
   logic [31:0]         wraddr;
   logic [31:0]         wr_data;
   logic [31:0]         rd_data;
   pic_prio_pkg::prio_t meipt;
   pic_prio_pkg::prio_t meicurpl;
   logic                mexintpend;
   logic                mhwakeup;
   pic_prio_pkg::id_t   claimid;
   pic_prio_pkg::prio_t pl;

   // Reference model state
   pic_prio_pkg::prio_t prio_m [16];
   logic [15:0]         en_m;
   logic [15:0]         pol_m;
   logic [15:0]         edge_m;
   logic [15:0]         latch_m;   // Edge requests not yet cleared
   logic                rev_m;
   int                  errors = 0;
   int                  cycles = 0;

   pic_ctrl i_pic_ctrl (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
         $display("Something failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Helpers

   function automatic logic [31:0] reg_addr(input logic [31:0] ofs, input int id);
      return pic_map_pkg::PIC_BASE + ofs + 32'(id) * 32'd4;
   endfunction

   // Larger always wins, 0 strongest when reversed
   function automatic pic_prio_pkg::prio_t eff(input pic_prio_pkg::prio_t p);
      return rev_m ? 4'hF - p : p;
   endfunction

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      errors++;
      $display("** Error %s: got %h, expected %h", name, got, exp);
   endtask

   // Writes one register and mirrors it in the model
   task automatic write_reg(input logic [31:0] ofs, input int id, input logic [31:0] data);
      @(negedge clk);
      wren    = 1'b1;
      wraddr  = reg_addr(ofs, id);
      wr_data = data;
      @(negedge clk);
      wren = 1'b0;
      if (ofs == pic_map_pkg::CONFIG_OFS) begin
         rev_m = data[0];
      end else if (id != 0) begin
         case (ofs)
            pic_map_pkg::PRIO_OFS:   prio_m[id] = data[3:0];
            pic_map_pkg::ENABLE_OFS: en_m[id] = data[0];
            pic_map_pkg::GWCFG_OFS:  {edge_m[id], pol_m[id]} = data[1:0];
            pic_map_pkg::GWCLR_OFS:  latch_m[id] = 1'b0;
            default: ;
         endcase
      end
   endtask

   task automatic read_check(input logic [31:0] addr, input logic [31:0] exp);
      logic [31:0] got;
      @(negedge clk);
      rden   = 1'b1;
      rdaddr = addr;
      @(negedge clk);
      got  = rd_data;   // Valid the whole cycle after the sampling edge
      rden = 1'b0;
      assert (got == exp) else report_value("rd_data", got, exp);
   endtask

   task automatic drive_src(input logic [15:0] src);
      @(negedge clk);
      extintsrc_req = src;
      latch_m |= edge_m & (src ^ pol_m);
   endtask

   task automatic disable_all();
      for (int id = 1; id < 16; id++) begin
         write_reg(pic_map_pkg::ENABLE_OFS, id, 32'h0);
      end
   endtask

   // Settles, then compares the outputs with the model winner
   task automatic check_outputs();
      logic [15:0]         pend;
      pic_prio_pkg::id_t   exp_id;
      pic_prio_pkg::prio_t best;
      logic                exp_int;
      repeat (8) @(negedge clk);
      pend   = ((extintsrc_req ^ pol_m) | (edge_m & latch_m)) & 16'hFFFE;
      exp_id = '0;
      best   = '0;   // Reserved slot 0 keeps every tie at level 0
      for (int i = 1; i < 16; i++) begin
         if (pend[i] && en_m[i] && eff(prio_m[i]) > best) begin
            exp_id = pic_prio_pkg::id_t'(i);
            best   = eff(prio_m[i]);
         end
      end
      exp_int = (best > eff(meipt)) && (best > eff(meicurpl));
      assert (claimid == exp_id) else report_value("claimid", 32'(claimid), 32'(exp_id));
      assert (pl == eff(best)) else report_value("pl", 32'(pl), 32'(eff(best)));
      assert (mexintpend == exp_int)
         else report_value("mexintpend", 32'(mexintpend), 32'(exp_int));
      assert (mhwakeup == (best == 4'hF))
         else report_value("mhwakeup", 32'(mhwakeup), 32'(best == 4'hF));
      read_check(reg_addr(pic_map_pkg::PEND_OFS, 0), {16'h0, pend});
   endtask

   ////////////////////////////////////////
   // Test sequence

   initial begin
      logic [31:0] data;
      void'($urandom(56));
      arst_n        = 1'b0;
      extintsrc_req = '0;
      rden          = 1'b0;
      rdaddr        = '0;
      wren          = 1'b0;
      wraddr        = '0;
      wr_data       = '0;
      meipt         = '0;
      meicurpl      = '0;
      prio_m        = '{default: '0};
      en_m          = '0;
      pol_m         = '0;
      edge_m        = '0;
      latch_m       = '0;
      rev_m         = 1'b0;
      repeat (10) @(negedge clk);
      arst_n = 1'b1;

      // Read-back of every field, slot 0 and an unmapped address
      for (int id = 1; id < 16; id++) begin
         data = $urandom;
         write_reg(pic_map_pkg::PRIO_OFS, id, data);
         read_check(reg_addr(pic_map_pkg::PRIO_OFS, id), {28'h0, data[3:0]});
         write_reg(pic_map_pkg::GWCFG_OFS, id, data);
         read_check(reg_addr(pic_map_pkg::GWCFG_OFS, id), {30'h0, data[1:0]});
         write_reg(pic_map_pkg::GWCFG_OFS, id, 32'h0);
         write_reg(pic_map_pkg::ENABLE_OFS, id, data >> 4);
         read_check(reg_addr(pic_map_pkg::ENABLE_OFS, id), {31'h0, data[4]});
      end
      write_reg(pic_map_pkg::PRIO_OFS, 0, 32'hF);
      read_check(reg_addr(pic_map_pkg::PRIO_OFS, 0), 32'h0);
      read_check(reg_addr(32'h6000, 1), 32'h0);
      write_reg(pic_map_pkg::CONFIG_OFS, 0, 32'h1);
      read_check(reg_addr(pic_map_pkg::CONFIG_OFS, 0), 32'h1);
      write_reg(pic_map_pkg::CONFIG_OFS, 0, 32'h0);

      // Single level source against both thresholds
      disable_all();
      write_reg(pic_map_pkg::PRIO_OFS, 5, 32'h9);
      write_reg(pic_map_pkg::ENABLE_OFS, 5, 32'h1);
      meipt    = 4'h3;
      meicurpl = 4'h2;
      drive_src(16'h0020);
      check_outputs();
      write_reg(pic_map_pkg::ENABLE_OFS, 5, 32'h0);
      check_outputs();
      write_reg(pic_map_pkg::ENABLE_OFS, 5, 32'h1);
      meipt = 4'h9;
      check_outputs();

      // Random arbitration, reversed order from round 12
      for (int r = 0; r < 20; r++) begin
         if (r == 12) begin
            write_reg(pic_map_pkg::CONFIG_OFS, 0, 32'h1);
         end
         for (int id = 1; id < 16; id++) begin
            // Narrow range in odd rounds forces ties
            write_reg(pic_map_pkg::PRIO_OFS, id, (r % 2 == 1) ? $urandom_range(2, 0) : $urandom);
            write_reg(pic_map_pkg::ENABLE_OFS, id, 32'($urandom_range(3, 0) != 0));
         end
         meipt    = pic_prio_pkg::prio_t'($urandom_range(6, 0));
         meicurpl = pic_prio_pkg::prio_t'($urandom_range(6, 0));
         drive_src(16'($urandom));
         check_outputs();
      end

      // Edge latch and clear, then an inverted level source
      write_reg(pic_map_pkg::CONFIG_OFS, 0, 32'h0);
      disable_all();
      drive_src(16'h0000);
      meipt    = '0;
      meicurpl = '0;
      write_reg(pic_map_pkg::GWCFG_OFS, 7, 32'h2);
      write_reg(pic_map_pkg::PRIO_OFS, 7, 32'h6);
      write_reg(pic_map_pkg::ENABLE_OFS, 7, 32'h1);
      drive_src(16'h0080);
      @(negedge clk);
      drive_src(16'h0000);
      check_outputs();
      write_reg(pic_map_pkg::GWCLR_OFS, 7, 32'h1);
      check_outputs();
      write_reg(pic_map_pkg::GWCFG_OFS, 3, 32'h1);
      write_reg(pic_map_pkg::PRIO_OFS, 3, 32'h4);
      write_reg(pic_map_pkg::ENABLE_OFS, 3, 32'h1);
      check_outputs();

      // Strongest level in both orders
      meipt    = 4'h5;
      meicurpl = 4'h1;
      write_reg(pic_map_pkg::CONFIG_OFS, 0, 32'h1);
      write_reg(pic_map_pkg::PRIO_OFS, 3, 32'h0);
      check_outputs();
      write_reg(pic_map_pkg::CONFIG_OFS, 0, 32'h0);
      write_reg(pic_map_pkg::PRIO_OFS, 3, 32'hF);
      check_outputs();

      $display("Errors: %0d in checks, %0d in assertions", errors, i_pic_ctrl.i_props.fail_cnt);
      if (errors == 0 && i_pic_ctrl.i_props.fail_cnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
design/pic_prio_pkg.sv
design/pic_map_pkg.sv
design/pic_cfg_if.sv
design/pic_regs.sv
design/pic_gateway_bank.sv
design/pic_arbiter.sv
design/pic_notify.sv
design/pic_ctrl.sv
test/pic_ctrl_props.sv
test/pic_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the PIC testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --timing -Wno-fatal --top-module pic_ctrl_tb \
   -f sources.f -o pic_ctrl_sim \
   && ./obj_dir/pic_ctrl_sim +verilator+error+limit+100 > sim.log 2>&1 \
   || echo "Build or simulation did not complete" >> sim.log

cat sim.log
grep -qx "Everything OK" sim.log && exit 0 || exit 1
